/* source/sensor_pkg.sv */
// ADS1292 data types, operation codes, opcodes, register settings and SPI timing
package sensor_pkg;

	// ==================================================================
	// Data widths
	// ==================================================================
	typedef logic [7:0]  ads_byte_t;   // One SPI byte or register value
	typedef logic [23:0] ads_sample_t; // Channel sample or status word
	typedef logic [71:0] ads_frame_t;  // Status, ch1, ch2 in RDATAC order

	// Operation requested by the core from the SPI controller
	typedef enum logic [1:0] {
		ADS_OP_NONE, // No request
		ADS_OP_CMD,  // Single opcode byte
		ADS_OP_WREG, // Three byte register write
		ADS_OP_READ  // Wait for DRDY, then 72 bit frame
	} ads_op_t;

	// ==================================================================
	// Opcodes and register map
	// ==================================================================
	localparam ads_byte_t ADS_CMD_SDATAC    = 8'h11; // Stop continuous read
	localparam ads_byte_t ADS_CMD_RDATAC    = 8'h10; // Start continuous read
	localparam ads_byte_t ADS_CMD_WREG_BASE = 8'h40; // ORed with register address

	localparam ads_byte_t ADS_REG_CONFIG1 = 8'h01;
	localparam ads_byte_t ADS_VAL_CONFIG1 = 8'h02; // 500 SPS, continuous conversion
	localparam ads_byte_t ADS_REG_CH1SET  = 8'h04;
	localparam ads_byte_t ADS_VAL_CH1SET  = 8'h00; // Normal input, gain 6
	localparam ads_byte_t ADS_REG_CH2SET  = 8'h05;
	localparam ads_byte_t ADS_VAL_CH2SET  = 8'h00;

	// ==================================================================
	// Timing
	// ==================================================================
	localparam int SPI_HALF_CLKS       = 4;  // i_clk cycles per SCLK half period
	localparam int ADS_RESET_CLKS      = 16; // RESET pin low time after system reset
	localparam int ADS_SETUP_WAIT_CLKS = 32; // Core delay before first command

	// Give up on DRDY after this many cycles of a read
	localparam logic [19:0] DRDY_TIMEOUT_CLKS = 20'd4000;

endpackage

/* source/uart_pkg.sv */
// UART data types, bit timing, packet length and packet header byte
package uart_pkg;

	typedef logic [7:0]  uart_byte_t;   // One 8N1 payload byte
	typedef logic [39:0] uart_packet_t; // Header plus two 16 bit samples

	// Bit period in i_clk cycles
	localparam int UART_CLKS_PER_BIT = 16;

	// Bytes per packet, sent most significant first
	localparam int UART_PACKET_BYTES = 5;

	// First byte of every packet, lets the PC find frame boundaries
	localparam uart_byte_t UART_PACKET_HEADER = 8'hAE;

endpackage

/* source/ads1292_spi_controller.sv */
// ADS1292 SPI master for commands, register writes and DRDY paced frame reads
`timescale 1ns/10ps
module ads1292_spi_controller (
	input  logic                   i_clk,
	input  logic                   i_rst_n,
	// Host side
	input  sensor_pkg::ads_op_t    i_op,           // One cycle request
	input  sensor_pkg::ads_byte_t  i_command,
	input  sensor_pkg::ads_byte_t  i_reg_addr,
	input  sensor_pkg::ads_byte_t  i_data_in,
	output sensor_pkg::ads_frame_t o_data_out,     // Valid with o_rdatac_ready
	output logic                   o_rdatac_ready,
	output logic                   o_busy,
	output logic                   o_fail,         // DRDY timeout pulse
	// SPI side
	output logic                   o_spi_clk,
	input  logic                   i_spi_miso,
	output logic                   o_spi_mosi,
	input  logic                   i_drdy_n,
	output logic                   o_ads_reset_n,
	output logic                   o_ads_start,
	input  logic                   i_start_level,  // START level from core
	output logic                   o_spi_cs_n
);
	import sensor_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_WAIT_DRDY,
		ST_SHIFT,
		ST_CS_RELEASE
	} spi_state_t;

	spi_state_t  state;
	ads_op_t     op_q;        // Operation in progress
	logic [1:0]  div_cnt;     // SCLK half period divider
	logic [6:0]  bit_cnt;     // Falling edges seen
	logic [6:0]  last_bit;    // Index of final bit for this op
	logic [19:0] timeout_cnt;
	logic [4:0]  rst_cnt;
	ads_frame_t  shift_reg;   // TX bits out the top, MISO in the bottom
	logic        half_end;

	assign half_end   = (div_cnt == 2'(SPI_HALF_CLKS - 1));
	assign o_data_out = shift_reg; // Full frame after the last falling edge

	// Transfer length per operation
	always_comb begin
		case (op_q)
			ADS_OP_CMD:  last_bit = 7'd7;
			ADS_OP_WREG: last_bit = 7'd23;
			default:     last_bit = 7'd71;
		endcase
	end

	// ==================================================================
	// Chip reset release and START pin
	// ==================================================================
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			rst_cnt       <= '0;
			o_ads_reset_n <= 1'b0; // Hold chip in reset
			o_ads_start   <= 1'b0;
		end else begin
			o_ads_start <= i_start_level;
			if (!o_ads_reset_n) begin
				if (rst_cnt == 5'(ADS_RESET_CLKS - 1))
					o_ads_reset_n <= 1'b1;
				rst_cnt <= rst_cnt + 5'd1;
			end
		end
	end

	// ==================================================================
	// Transfer FSM
	// ==================================================================
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			state          <= ST_IDLE;
			op_q           <= ADS_OP_NONE;
			div_cnt        <= '0;
			bit_cnt        <= '0;
			timeout_cnt    <= '0;
			o_busy         <= 1'b0;
			o_rdatac_ready <= 1'b0;
			o_fail         <= 1'b0;
			o_spi_clk      <= 1'b0; // CPOL 0
			o_spi_mosi     <= 1'b0;
			o_spi_cs_n     <= 1'b1;
		end else begin
			o_rdatac_ready <= 1'b0;
			o_fail         <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (i_op != ADS_OP_NONE) begin
						op_q        <= i_op;
						o_busy      <= 1'b1;
						div_cnt     <= '0;
						bit_cnt     <= '0;
						timeout_cnt <= '0;
						if (i_op == ADS_OP_READ) begin
							state <= ST_WAIT_DRDY;
						end else begin
							o_spi_cs_n <= 1'b0;
							state      <= ST_SHIFT;
						end
					end
				end
				ST_WAIT_DRDY: begin
					if (!i_drdy_n) begin // Frame ready on DOUT
						o_spi_cs_n <= 1'b0;
						state      <= ST_SHIFT;
					end else if (timeout_cnt == DRDY_TIMEOUT_CLKS - 20'd1) begin
						o_fail <= 1'b1;
						o_busy <= 1'b0;
						state  <= ST_IDLE;
					end else begin
						timeout_cnt <= timeout_cnt + 20'd1;
					end
				end
				ST_SHIFT: begin
					if (half_end) begin
						div_cnt   <= '0;
						o_spi_clk <= ~o_spi_clk;
						if (!o_spi_clk) begin
							o_spi_mosi <= shift_reg[71]; // Rising edge, MSB first
						end else if (bit_cnt == last_bit) begin
							state <= ST_CS_RELEASE; // Last falling edge
						end else begin
							bit_cnt <= bit_cnt + 7'd1;
						end
					end else begin
						div_cnt <= div_cnt + 2'd1;
					end
				end
				ST_CS_RELEASE: begin
					// CS held one half period past the last edge
					if (half_end) begin
						div_cnt        <= '0;
						o_spi_cs_n     <= 1'b1;
						o_spi_mosi     <= 1'b0;
						o_busy         <= 1'b0;
						o_rdatac_ready <= (op_q == ADS_OP_READ);
						state          <= ST_IDLE;
					end else begin
						div_cnt <= div_cnt + 2'd1;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Shift register loads in idle, samples MISO on the falling edge
	always_ff @(posedge i_clk) begin
		if (state == ST_IDLE) begin
			case (i_op)
				ADS_OP_CMD:  shift_reg <= {i_command, 64'h0};
				ADS_OP_WREG: shift_reg <= {ADS_CMD_WREG_BASE | i_reg_addr, 8'h00, i_data_in, 48'h0};
				default:     shift_reg <= '0; // Reads keep MOSI low
			endcase
		end else if (state == ST_SHIFT && half_end && o_spi_clk) begin
			shift_reg <= {shift_reg[70:0], i_spi_miso};
		end
	end

endmodule

/* source/uart_tx_serializer.sv */
// UART transmitter that sends a 40 bit packet as five 8N1 bytes, MSB byte first
`timescale 1ns/10ps
module uart_tx_serializer (
	input  logic                   i_clk,
	input  logic                   i_rst_n,
	input  uart_pkg::uart_packet_t i_tx_data,
	input  logic                   i_tx_valid, // One cycle strobe
	output logic                   o_tx_ready, // Low while a packet is on the line
	output logic                   o_uart_txd
);
	import uart_pkg::*;

	uart_packet_t pkt_sr;     // Remaining bytes, current one on top
	uart_byte_t   first_byte;
	uart_byte_t   next_byte;
	logic [9:0]   frame_sr;   // Stop, data, start; bit 0 on the line
	logic [3:0]   tick_cnt;   // Cycles within one bit
	logic [3:0]   bit_idx;    // 0 start, 1..8 data, 9 stop
	logic [2:0]   byte_cnt;
	logic         accept;
	logic         bit_end;
	logic         byte_end;

	assign first_byte = i_tx_data[39:32];
	assign next_byte  = pkt_sr[31:24];
	assign accept     = i_tx_valid && o_tx_ready;
	assign bit_end    = !o_tx_ready && (tick_cnt == 4'(UART_CLKS_PER_BIT - 1));
	assign byte_end   = bit_end && (bit_idx == 4'd9);
	assign o_uart_txd = frame_sr[0];

	// ==================================================================
	// Bit and byte sequencing
	// ==================================================================
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			frame_sr   <= '1; // Line idles high
			o_tx_ready <= 1'b1;
			tick_cnt   <= '0;
			bit_idx    <= '0;
			byte_cnt   <= '0;
		end else if (accept) begin
			frame_sr   <= {1'b1, first_byte, 1'b0};
			o_tx_ready <= 1'b0;
			tick_cnt   <= '0;
			bit_idx    <= '0;
			byte_cnt   <= '0;
		end else if (!o_tx_ready) begin
			if (bit_end) begin
				tick_cnt <= '0;
				if (byte_end) begin
					bit_idx <= '0;
					if (byte_cnt == 3'(UART_PACKET_BYTES - 1)) begin
						o_tx_ready <= 1'b1; // Fifth stop bit done
					end else begin
						byte_cnt <= byte_cnt + 3'd1;
						frame_sr <= {1'b1, next_byte, 1'b0};
					end
				end else begin
					bit_idx  <= bit_idx + 4'd1;
					frame_sr <= {1'b1, frame_sr[9:1]}; // LSB first
				end
			end else begin
				tick_cnt <= tick_cnt + 4'd1;
			end
		end
	end

	// Packet holding register
	always_ff @(posedge i_clk) begin
		if (accept)
			pkt_sr <= i_tx_data;
		else if (byte_end)
			pkt_sr <= {pkt_sr[31:0], 8'h00};
	end

endmodule

/* source/sensor_core.sv */
// Sensor core FSM for ADS1292 setup, run/stop sequencing and UART packet building
`timescale 1ns/10ps
module sensor_core (
	input  logic                   i_clk,
	input  logic                   i_rst_n,
	input  logic                   i_run,          // Run switch level
	output logic                   o_chip_set,
	output logic                   o_run_set,
	output logic                   o_core_busy,
	output logic                   o_error,
	// ADS1292 controller
	output sensor_pkg::ads_op_t    o_ads_op,
	output sensor_pkg::ads_byte_t  o_ads_command,
	output sensor_pkg::ads_byte_t  o_ads_reg_addr,
	output sensor_pkg::ads_byte_t  o_ads_data_in,
	output logic                   o_ads_start,    // START level request
	input  sensor_pkg::ads_frame_t i_ads_data_out,
	input  logic                   i_ads_rdatac_ready,
	input  logic                   i_ads_busy,
	input  logic                   i_ads_fail,
	// UART transmitter
	output uart_pkg::uart_packet_t o_tx_data,
	output logic                   o_tx_valid,
	input  logic                   i_tx_ready
);
	import sensor_pkg::*;
	import uart_pkg::*;

	typedef enum logic [3:0] {
		ST_POR_WAIT, ST_SDATAC, ST_WREG_CFG1, ST_WREG_CH1, ST_WREG_CH2, ST_WAIT,
		ST_IDLE, ST_RDATAC, ST_READ, ST_RUN_WAIT, ST_STOP
	} core_state_t;

	core_state_t state;
	core_state_t ret_state;  // Where a wait state goes next
	logic        wait_hold;  // Skip cycle until busy rises
	logic [4:0]  por_cnt;
	ads_sample_t ch1_sample;
	ads_sample_t ch2_sample;

	assign ch1_sample  = i_ads_data_out[47:24];
	assign ch2_sample  = i_ads_data_out[23:0];
	assign o_core_busy = (state != ST_IDLE) && (state != ST_RUN_WAIT);

	// ==================================================================
	// Sequencer
	// ==================================================================
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			state       <= ST_POR_WAIT;
			ret_state   <= ST_POR_WAIT;
			wait_hold   <= 1'b0;
			por_cnt     <= '0;
			o_ads_op    <= ADS_OP_NONE;
			o_ads_start <= 1'b0;
			o_chip_set  <= 1'b0;
			o_run_set   <= 1'b0;
			o_tx_valid  <= 1'b0;
			o_error     <= 1'b0;
		end else begin
			o_ads_op   <= ADS_OP_NONE;
			o_tx_valid <= 1'b0;
			if (i_ads_fail)
				o_error <= 1'b1; // Sticky until reset
			if (i_ads_rdatac_ready && i_tx_ready)
				o_tx_valid <= 1'b1; // Frame dropped when UART is busy
			case (state)
				ST_POR_WAIT: begin
					por_cnt <= por_cnt + 5'd1;
					if (por_cnt == 5'(ADS_SETUP_WAIT_CLKS - 1))
						state <= ST_SDATAC;
				end
				ST_SDATAC, ST_WREG_CFG1, ST_WREG_CH1, ST_WREG_CH2: begin
					if (!i_ads_busy) begin
						o_ads_op  <= (state == ST_SDATAC) ? ADS_OP_CMD : ADS_OP_WREG;
						wait_hold <= 1'b1;
						state     <= ST_WAIT;
						case (state)
							ST_SDATAC:    ret_state <= ST_WREG_CFG1;
							ST_WREG_CFG1: ret_state <= ST_WREG_CH1;
							ST_WREG_CH1:  ret_state <= ST_WREG_CH2;
							default:      ret_state <= ST_IDLE;
						endcase
					end
				end
				ST_WAIT, ST_RUN_WAIT: begin
					if (wait_hold)
						wait_hold <= 1'b0;
					else if (!i_ads_busy)
						state <= ret_state;
				end
				ST_IDLE: begin
					o_chip_set <= 1'b1; // Setup done
					o_run_set  <= 1'b0;
					if (i_run)
						state <= ST_RDATAC;
				end
				ST_RDATAC: begin
					if (!i_ads_busy) begin
						o_ads_op    <= ADS_OP_CMD;
						o_run_set   <= 1'b1;
						o_ads_start <= 1'b1; // Conversions begin
						ret_state   <= ST_READ;
						wait_hold   <= 1'b1;
						state       <= ST_WAIT;
					end
				end
				ST_READ: begin
					if (!i_run) begin
						state <= ST_STOP;
					end else if (!i_ads_busy) begin
						o_ads_op  <= ADS_OP_READ;
						ret_state <= ST_READ;
						wait_hold <= 1'b1;
						state     <= ST_RUN_WAIT;
					end
				end
				ST_STOP: begin
					o_ads_start <= 1'b0;
					if (!i_ads_busy) begin
						o_ads_op  <= ADS_OP_CMD; // SDATAC
						ret_state <= ST_IDLE;
						wait_hold <= 1'b1;
						state     <= ST_WAIT;
					end
				end
				default: state <= ST_POR_WAIT;
			endcase
		end
	end

	// Request payload and packet register
	always_ff @(posedge i_clk) begin
		case (state)
			ST_SDATAC, ST_STOP: o_ads_command <= ADS_CMD_SDATAC;
			ST_RDATAC:          o_ads_command <= ADS_CMD_RDATAC;
			ST_WREG_CFG1: begin
				o_ads_reg_addr <= ADS_REG_CONFIG1;
				o_ads_data_in  <= ADS_VAL_CONFIG1;
			end
			ST_WREG_CH1: begin
				o_ads_reg_addr <= ADS_REG_CH1SET;
				o_ads_data_in  <= ADS_VAL_CH1SET;
			end
			ST_WREG_CH2: begin
				o_ads_reg_addr <= ADS_REG_CH2SET;
				o_ads_data_in  <= ADS_VAL_CH2SET;
			end
			default: ;
		endcase
		// Header, then top 16 bits of each channel
		if (i_ads_rdatac_ready)
			o_tx_data <= {UART_PACKET_HEADER, ch1_sample[23:8], ch2_sample[23:8]};
	end

endmodule

/* source/khu_sensor_top.sv */
// Top level connecting the sensor core, ADS1292 SPI controller and UART transmitter
`timescale 1ns/10ps
module khu_sensor_top (
	input  logic i_clk,
	input  logic i_rst_n,
	input  logic i_run,         // Run switch
	output logic o_chip_set,    // Status outputs
	output logic o_run_set,
	output logic o_core_busy,
	output logic o_error,
	output logic o_uart_txd,    // To PC
	output logic o_ads_sclk,    // ADS1292 SPI
	input  logic i_ads_miso,
	output logic o_ads_mosi,
	input  logic i_ads_drdy_n,
	output logic o_ads_reset_n,
	output logic o_ads_start,
	output logic o_ads_cs_n
);
	import sensor_pkg::*;
	import uart_pkg::*;

	// ==================================================================
	// Core to SPI controller
	// ==================================================================
	ads_op_t      w_ads_op;
	ads_byte_t    w_ads_command;
	ads_byte_t    w_ads_reg_addr;
	ads_byte_t    w_ads_data_in;
	ads_frame_t   w_ads_data_out;
	logic         w_ads_rdatac_ready;
	logic         w_ads_busy;
	logic         w_ads_fail;
	logic         w_start_level;

	// Core to UART
	uart_packet_t w_tx_data;
	logic         w_tx_valid;
	logic         w_tx_ready;

	sensor_core sensor_core (
		.i_clk              (i_clk),
		.i_rst_n            (i_rst_n),
		.i_run              (i_run),
		.o_chip_set         (o_chip_set),
		.o_run_set          (o_run_set),
		.o_core_busy        (o_core_busy),
		.o_error            (o_error),
		.o_ads_op           (w_ads_op),
		.o_ads_command      (w_ads_command),
		.o_ads_reg_addr     (w_ads_reg_addr),
		.o_ads_data_in      (w_ads_data_in),
		.o_ads_start        (w_start_level),
		.i_ads_data_out     (w_ads_data_out),
		.i_ads_rdatac_ready (w_ads_rdatac_ready),
		.i_ads_busy         (w_ads_busy),
		.i_ads_fail         (w_ads_fail),
		.o_tx_data          (w_tx_data),
		.o_tx_valid         (w_tx_valid),
		.i_tx_ready         (w_tx_ready)
	);

	ads1292_spi_controller ads1292_spi_controller (
		.i_clk          (i_clk),
		.i_rst_n        (i_rst_n),
		.i_op           (w_ads_op),
		.i_command      (w_ads_command),
		.i_reg_addr     (w_ads_reg_addr),
		.i_data_in      (w_ads_data_in),
		.o_data_out     (w_ads_data_out),
		.o_rdatac_ready (w_ads_rdatac_ready),
		.o_busy         (w_ads_busy),
		.o_fail         (w_ads_fail),
		.o_spi_clk      (o_ads_sclk),
		.i_spi_miso     (i_ads_miso),
		.o_spi_mosi     (o_ads_mosi),
		.i_drdy_n       (i_ads_drdy_n),  // Active low data ready
		.o_ads_reset_n  (o_ads_reset_n),
		.o_ads_start    (o_ads_start),
		.i_start_level  (w_start_level),
		.o_spi_cs_n     (o_ads_cs_n)
	);

	uart_tx_serializer uart_tx_serializer (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_tx_data  (w_tx_data),
		.i_tx_valid (w_tx_valid),
		.o_tx_ready (w_tx_ready),
		.o_uart_txd (o_uart_txd)
	);

endmodule

/* tests/ads1292_model.sv */
// Behavioral ADS1292 SPI slave with DRDY pacing, table frames and a MOSI byte log
`timescale 1ns/10ps
module ads1292_model #(
	parameter int N_FRAMES    = 3,    // Table frames, returned in order and reused
	parameter int DRDY_PERIOD = 1600  // i_clk cycles between conversions
) (
	input  logic                   i_clk,
	input  logic                   i_sclk,
	input  logic                   i_cs_n,
	input  logic                   i_mosi,
	input  logic                   i_start,     // START pin from the FPGA
	input  logic                   i_hold_drdy, // Keeps DRDY high
	input  sensor_pkg::ads_frame_t i_frames [N_FRAMES],
	output logic                   o_miso,
	output logic                   o_drdy_n
);
	import sensor_pkg::*;

	ads_byte_t  mosi_log[$];         // Every byte seen on MOSI
	ads_byte_t  rx_byte    = '0;
	ads_frame_t tx_frame   = '0;     // Bits still to go out on MISO
	int         rx_bits    = 0;
	int         frame_idx  = 0;
	int         drdy_cnt   = 0;
	logic       sclk_q     = 1'b0;
	logic       cs_q       = 1'b1;
	logic       miso_q     = 1'b0;
	logic       drdy_q     = 1'b1;
	logic       frame_xfer = 1'b0;   // This CS cycle reads a frame

	assign o_miso   = miso_q;
	assign o_drdy_n = drdy_q;

	// Pin edges show up one i_clk later, well inside an SCLK half period
	always @(posedge i_clk) begin
		sclk_q <= i_sclk;
		cs_q   <= i_cs_n;
		// ==================================================================
		// Conversion timing
		// ==================================================================
		if (!i_start || i_hold_drdy) begin
			drdy_cnt <= 0;
			drdy_q   <= 1'b1;
		end else if (drdy_cnt == DRDY_PERIOD - 1) begin
			drdy_cnt <= 0;
			drdy_q   <= 1'b0; // New frame ready
		end else begin
			drdy_cnt <= drdy_cnt + 1;
			if (cs_q && !i_cs_n)
				drdy_q <= 1'b1; // Read has begun
		end
		// CS edges
		if (cs_q && !i_cs_n) begin
			frame_xfer <= !drdy_q;
			tx_frame   <= drdy_q ? '0 : i_frames[frame_idx];
			rx_bits    <= 0;
		end else if (!cs_q && i_cs_n) begin
			miso_q     <= 1'b0;
			frame_xfer <= 1'b0;
			if (frame_xfer)
				frame_idx <= (frame_idx + 1) % N_FRAMES; // Next table frame
		end
		// ==================================================================
		// SPI mode 1 shifting
		// ==================================================================
		if (!sclk_q && i_sclk) begin
			miso_q   <= tx_frame[71]; // MSB first
			tx_frame <= {tx_frame[70:0], 1'b0};
		end else if (sclk_q && !i_sclk) begin
			rx_byte <= {rx_byte[6:0], i_mosi};
			if (rx_bits == 7) begin
				mosi_log.push_back({rx_byte[6:0], i_mosi});
				rx_bits <= 0;
			end else begin
				rx_bits <= rx_bits + 1;
			end
		end
	end

endmodule

/* tests/tb_khu_sensor_top.sv */
// Testbench for the sensor hub top with ADS1292 model, UART decoder and frame table
`timescale 1ns/10ps
module tb_khu_sensor_top;
	import sensor_pkg::*;
	import uart_pkg::*;

	typedef enum int {
		COND_ADS_RESET,
		COND_CHIP_SET,
		COND_RUN_SET,
		COND_RUN_CLEAR,
		COND_ADS_START,
		COND_ERROR
	} cond_t;

	logic clk = 1'b0;
	logic rst_n;
	logic run;
	logic hold_drdy;
	logic chip_set;
	logic run_set;
	logic core_busy;
	logic error;
	logic uart_txd;
	logic ads_sclk;
	logic ads_miso;
	logic ads_mosi;
	logic ads_drdy_n;
	logic ads_reset_n;
	logic ads_start;
	logic ads_cs_n;

	// Stimulus table, frames and their packets
	ads_frame_t   frame_tbl [3];
	uart_packet_t pkt_tbl   [3];
	ads_byte_t    setup_bytes [10] = '{8'h11, 8'h41, 8'h00, 8'h02, 8'h44,
	                                   8'h00, 8'h00, 8'h45, 8'h00, 8'h00};

	integer seed;
	int     n_checks  = 0;
	int     n_errors  = 0;
	int     rx_errors = 0; // Framing errors from the decoder

	// UART decoder state
	uart_packet_t rx_q[$];          // Complete packets
	uart_packet_t rx_pkt    = '0;
	uart_byte_t   rx_byte   = '0;
	logic         rx_busy   = 1'b0;
	int           rx_cnt    = 0;
	int           rx_bit    = 0;
	int           rx_nbytes = 0;
	int           pkt_starts = 0;   // Start bits that open a packet

	always #10 clk = ~clk; // 50 MHz

	khu_sensor_top uut (
		.i_clk         (clk),
		.i_rst_n       (rst_n),
		.i_run         (run),
		.o_chip_set    (chip_set),
		.o_run_set     (run_set),
		.o_core_busy   (core_busy),
		.o_error       (error),
		.o_uart_txd    (uart_txd),
		.o_ads_sclk    (ads_sclk),
		.i_ads_miso    (ads_miso),
		.o_ads_mosi    (ads_mosi),
		.i_ads_drdy_n  (ads_drdy_n),
		.o_ads_reset_n (ads_reset_n),
		.o_ads_start   (ads_start),
		.o_ads_cs_n    (ads_cs_n)
	);

	ads1292_model #(.N_FRAMES(3)) model (
		.i_clk       (clk),
		.i_sclk      (ads_sclk),
		.i_cs_n      (ads_cs_n),
		.i_mosi      (ads_mosi),
		.i_start     (ads_start),
		.i_hold_drdy (hold_drdy),
		.i_frames    (frame_tbl),
		.o_miso      (ads_miso),
		.o_drdy_n    (ads_drdy_n)
	);

	// ======================================================================
	// UART decoder with mid-bit sampling
	// ======================================================================
	always @(posedge clk) begin
		if (!rx_busy) begin
			if (rst_n && !uart_txd) begin // Start bit edge
				rx_busy = 1'b1;
				rx_cnt  = 0;
				if (rx_nbytes == 0)
					pkt_starts++;
			end
		end else begin
			rx_cnt++;
			if (rx_cnt % 16 == 7) begin
				rx_bit = rx_cnt / 16;
				if (rx_bit == 0) begin
					if (uart_txd) begin
						rx_errors++;
						$display("UART start bit did not stay low");
						rx_busy = 1'b0;
					end
				end else if (rx_bit <= 8) begin
					rx_byte[rx_bit - 1] = uart_txd; // LSB first
				end else begin
					if (!uart_txd) begin
						rx_errors++;
						$display("UART stop bit missing");
					end
					rx_pkt  = {rx_pkt[31:0], rx_byte};
					rx_busy = 1'b0;
					if (rx_nbytes == 4) begin
						rx_q.push_back(rx_pkt);
						rx_nbytes = 0;
					end else begin
						rx_nbytes++;
					end
				end
			end
		end
	end

	// ======================================================================
	// Compare tasks
	// ======================================================================
	task automatic check_byte(input string name, input ads_byte_t exp, input ads_byte_t act);
		n_checks++;
		if (act !== exp) begin
			n_errors++;
			$display("FAILED %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_packet(input string name, input uart_packet_t exp,
		input uart_packet_t act);
		n_checks++;
		if (act !== exp) begin
			n_errors++;
			$display("FAILED %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		n_checks++;
		if (act !== exp) begin
			n_errors++;
			$display("FAILED %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	// Status pin selected by a wait
	function automatic logic cond_met(input cond_t cond);
		case (cond)
			COND_ADS_RESET: return ads_reset_n;
			COND_CHIP_SET:  return chip_set;
			COND_RUN_SET:   return run_set;
			COND_RUN_CLEAR: return !run_set;
			COND_ADS_START: return ads_start;
			default:        return error;
		endcase
	endfunction

	// ======================================================================
	// Bounded waits
	// ======================================================================
	task automatic wait_cond(input cond_t cond, input int limit, output bit ok);
		int cnt;
		cnt = 0;
		while (!cond_met(cond) && cnt < limit) begin
			@(posedge clk);
			cnt++;
		end
		ok = cond_met(cond);
		if (!ok) begin
			n_errors++;
			$display("Timeout after %0d cycles waiting for %s", limit, cond.name());
		end
	endtask

	task automatic wait_log(input int n, input int limit, output bit ok);
		int cnt;
		cnt = 0;
		while (model.mosi_log.size() < n && cnt < limit) begin
			@(posedge clk);
			cnt++;
		end
		ok = (model.mosi_log.size() >= n);
		if (!ok) begin
			n_errors++;
			$display("Timeout with %0d MOSI bytes logged, %0d awaited",
				model.mosi_log.size(), n);
		end
	endtask

	task automatic wait_packet(input int limit, output bit ok);
		int cnt;
		cnt = 0;
		while (rx_q.size() == 0 && cnt < limit) begin
			@(posedge clk);
			cnt++;
		end
		ok = (rx_q.size() != 0);
		if (!ok) begin
			n_errors++;
			$display("Timeout after %0d cycles with no UART packet", limit);
		end
	endtask

	// ======================================================================
	// Test sequence
	// ======================================================================
	task automatic run_behaviors();
		uart_packet_t pkt;
		int           starts_at_stop;
		int           i;
		bit           ok;
		// Chip setup after reset
		check_flag("chip RESET low after reset", 1'b0, ads_reset_n);
		check_flag("core busy during setup", 1'b1, core_busy);
		wait_cond(COND_ADS_RESET, 100, ok);
		if (!ok)
			return;
		check_flag("no SPI byte before RESET release", 1'b1, model.mosi_log.size() == 0);
		wait_cond(COND_CHIP_SET, 5000, ok);
		if (!ok)
			return;
		check_flag("core idle after setup", 1'b0, core_busy);
		check_flag("START pin before run", 1'b0, ads_start);
		check_flag("setup byte count", 1'b1, model.mosi_log.size() == 10);
		for (i = 0; i < 10; i++)
			check_byte($sformatf("setup byte %0d", i), setup_bytes[i], model.mosi_log[i]);
		// Run start
		@(posedge clk);
		run <= 1'b1;
		wait_log(11, 1000, ok);
		if (!ok)
			return;
		check_byte("RDATAC byte", 8'h10, model.mosi_log[10]);
		wait_cond(COND_RUN_SET, 1000, ok);
		if (!ok)
			return;
		wait_cond(COND_ADS_START, 1000, ok);
		if (!ok)
			return;
		check_flag("run_set in run mode", 1'b1, run_set);
		// One packet per table frame
		for (i = 0; i < 3; i++) begin
			wait_packet(5000, ok);
			if (!ok)
				return;
			pkt = rx_q.pop_front();
			check_packet($sformatf("packet %0d", i), pkt_tbl[i], pkt);
		end
		// Lower run while a frame may still be in flight
		@(posedge clk);
		run <= 1'b0;
		wait_cond(COND_RUN_CLEAR, 5000, ok);
		if (!ok)
			return;
		check_byte("SDATAC byte at stop", 8'h11, model.mosi_log[model.mosi_log.size() - 1]);
		check_flag("START pin after stop", 1'b0, ads_start);
		check_flag("core idle after stop", 1'b0, core_busy);
		starts_at_stop = pkt_starts;
		repeat (2000) @(posedge clk);
		check_flag("no packet after stop", 1'b1, pkt_starts == starts_at_stop);
		check_flag("no error before DRDY timeout", 1'b0, error);
		// DRDY never comes
		@(posedge clk);
		hold_drdy <= 1'b1;
		run       <= 1'b1;
		wait_cond(COND_ERROR, 10000, ok);
	endtask

	initial begin
		logic [95:0] rnd;
		int          i;
		rst_n     = 1'b0;
		run       = 1'b0;
		hold_drdy = 1'b0;
		seed      = 32'h657635c8;
		// Status word, ch1, ch2; packet keeps the top 16 bits of each channel
		for (i = 0; i < 3; i++) begin
			rnd          = {$random(seed), $random(seed), $random(seed)};
			frame_tbl[i] = rnd[71:0];
			pkt_tbl[i]   = {UART_PACKET_HEADER, frame_tbl[i][47:32], frame_tbl[i][23:8]};
		end
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
		run_behaviors();
		$display("checks %0d, errors %0d", n_checks, n_errors + rx_errors);
		if (n_errors + rx_errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

/* filelist.f */
source/sensor_pkg.sv
source/uart_pkg.sv
source/ads1292_spi_controller.sv
source/uart_tx_serializer.sv
source/sensor_core.sv
source/khu_sensor_top.sv
tests/ads1292_model.sv
tests/tb_khu_sensor_top.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
set -e
cd "$(dirname "$0")"
verilator --binary --timing --timescale 1ns/10ps --top-module tb_khu_sensor_top -f filelist.f
out=$(./obj_dir/Vtb_khu_sensor_top)
echo "$out"
echo "$out" | grep -q "^sim passed$"
